/* hw/clint_pkg.sv */
package clint_pkg;

    // --------------------
    // Widths and counts
    // --------------------
    localparam int unsigned REG_ADDR_W = 16;
    localparam int unsigned REG_DATA_W = 64;
    // Fixed hart count of the cluster
    localparam int unsigned NR_HARTS   = 2;
    // Hart side and debug side requesters
    localparam int unsigned NR_PORTS   = 2;

    // Byte offset into the register block
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    // One 64-bit register word
    typedef logic [REG_DATA_W-1:0] reg_data_t;
    // One bit per hart
    typedef logic [NR_HARTS-1:0]   hart_mask_t;

    // --------------------
    // Register map
    // --------------------
    // Per-hart registers sit 8 bytes apart
    localparam int unsigned HART_STRIDE   = 8;
    localparam reg_addr_t   MSIP_BASE     = 16'h0000;
    localparam reg_addr_t   MTIMECMP_BASE = 16'h4000;
    localparam reg_addr_t   MTIME_BASE    = 16'hBFF8;

    // All ones keeps the timer interrupts quiet after reset
    localparam reg_data_t MTIMECMP_RESET = '1;

    // Port that received the most recent grant
    typedef enum logic [0:0] {
        OWNER_P0 = 1'b0,
        OWNER_P1 = 1'b1
    } grant_owner_e;

endpackage

/* hw/rtc_edge_sync.sv */
`timescale 1ns/1ps

module rtc_edge_sync (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic en_i,
    input  logic async_i,
    output logic rise_o
);

    // Two flop synchronizer stages
    logic sync1_q;
    logic sync2_q;
    // Previous synchronized level, for edge detection
    logic dly_q;

    // --------------------
    // Synchronizer chain
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sync1_q <= 1'b0;
            sync2_q <= 1'b0;
            dly_q   <= 1'b0;
        end else begin
            // First stage may go metastable
            sync1_q <= async_i;
            sync2_q <= sync1_q;
            dly_q   <= sync2_q;
        end
    end

    // One pulse per low to high transition of the clean level
    // Enable low masks the pulse but the chain keeps tracking
    assign rise_o = en_i & sync2_q & ~dly_q;

endmodule

/* hw/reg_bus_arbiter.sv */
`timescale 1ns/1ps

module reg_bus_arbiter
    import clint_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    // Port 0, hart side
    input  logic      p0_req_i,
    input  logic      p0_we_i,
    input  reg_addr_t p0_addr_i,
    input  reg_data_t p0_wdata_i,
    output logic      p0_rsp_o,
    output reg_data_t p0_rdata_o,
    // Port 1, debug side
    input  logic      p1_req_i,
    input  logic      p1_we_i,
    input  reg_addr_t p1_addr_i,
    input  reg_data_t p1_wdata_i,
    output logic      p1_rsp_o,
    output reg_data_t p1_rdata_o,
    // Register block side
    output logic      gnt_o,
    output logic      gnt_we_o,
    output reg_addr_t gnt_addr_o,
    output reg_data_t gnt_wdata_o,
    input  logic      blk_rsp_i,
    input  reg_data_t blk_rdata_i
);

    // Requests gathered into arrays indexed by port
    logic [NR_PORTS-1:0] req_in;
    logic [NR_PORTS-1:0] we_in;
    reg_addr_t           addr_in  [NR_PORTS];
    reg_data_t           wdata_in [NR_PORTS];

    // One-entry slot per port
    logic [NR_PORTS-1:0] slot_v_q;
    logic [NR_PORTS-1:0] slot_we_q;
    reg_addr_t           slot_addr_q  [NR_PORTS];
    reg_data_t           slot_wdata_q [NR_PORTS];

    // Last served port, also tags the response of the previous grant
    grant_owner_e last_owner_q;
    grant_owner_e sel;

    assign req_in      = {p1_req_i, p0_req_i};
    assign we_in       = {p1_we_i, p0_we_i};
    assign addr_in[0]  = p0_addr_i;
    assign addr_in[1]  = p1_addr_i;
    assign wdata_in[0] = p0_wdata_i;
    assign wdata_in[1] = p1_wdata_i;

    // --------------------
    // Round-robin select
    // --------------------
    always_comb begin
        unique case (slot_v_q)
            2'b01:   sel = OWNER_P0;
            2'b10:   sel = OWNER_P1;
            // Both waiting, the port not served last goes first
            2'b11:   sel = (last_owner_q == OWNER_P0) ? OWNER_P1 : OWNER_P0;
            default: sel = last_owner_q;
        endcase
    end

    // At most one grant per cycle
    assign gnt_o       = |slot_v_q;
    assign gnt_we_o    = slot_we_q[sel];
    assign gnt_addr_o  = slot_addr_q[sel];
    assign gnt_wdata_o = slot_wdata_q[sel];

    // --------------------
    // Slot control
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            slot_v_q     <= '0;
            // Port 0 wins the first tie
            last_owner_q <= OWNER_P1;
        end else begin
            for (int p = 0; p < NR_PORTS; p++) begin
                // A port never requests while its slot is still full
                if (req_in[p]) begin
                    slot_v_q[p] <= 1'b1;
                end else if (gnt_o && sel == grant_owner_e'(p)) begin
                    slot_v_q[p] <= 1'b0;
                end
            end
            if (gnt_o) begin
                last_owner_q <= sel;
            end
        end
    end

    // Slot payload, captured with the strobe
    always_ff @(posedge clk_i) begin
        for (int p = 0; p < NR_PORTS; p++) begin
            if (req_in[p]) begin
                slot_we_q[p]    <= we_in[p];
                slot_addr_q[p]  <= addr_in[p];
                slot_wdata_q[p] <= wdata_in[p];
            end
        end
    end

    // --------------------
    // Response steering
    // --------------------
    // Block answers one cycle after the grant, owner is still the tag
    assign p0_rsp_o   = blk_rsp_i && (last_owner_q == OWNER_P0);
    assign p1_rsp_o   = blk_rsp_i && (last_owner_q == OWNER_P1);
    assign p0_rdata_o = p0_rsp_o ? blk_rdata_i : '0;
    assign p1_rdata_o = p1_rsp_o ? blk_rdata_i : '0;

endmodule

/* hw/clint_regs.sv */
`timescale 1ns/1ps

module clint_regs
    import clint_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    // Synchronized real-time clock edge
    input  logic       tick_i,
    // Granted request from the arbiter
    input  logic       req_i,
    input  logic       we_i,
    input  reg_addr_t  addr_i,
    input  reg_data_t  wdata_i,
    output logic       rsp_o,
    output reg_data_t  rdata_o,
    // Interrupt lines, one per hart
    output hart_mask_t timer_irq_o,
    output hart_mask_t ipi_o
);

    // Architectural registers
    reg_data_t  mtime_q;
    reg_data_t  mtimecmp_q [NR_HARTS];
    hart_mask_t msip_q;

    // Decoded register hits
    hart_mask_t hit_msip;
    hart_mask_t hit_cmp;
    logic       hit_mtime;
    logic       wr_en;

    // Read path
    reg_data_t rdata_d;
    reg_data_t rdata_q;
    logic      rsp_q;

    // --------------------
    // Address decode
    // --------------------
    // Exact offsets only, anything else falls through as unmapped
    always_comb begin
        for (int i = 0; i < NR_HARTS; i++) begin
            hit_msip[i] = (addr_i == MSIP_BASE + reg_addr_t'(HART_STRIDE * i));
            hit_cmp[i]  = (addr_i == MTIMECMP_BASE + reg_addr_t'(HART_STRIDE * i));
        end
        hit_mtime = (addr_i == MTIME_BASE);
    end

    assign wr_en = req_i && we_i;

    // Read mux, zero for writes and unmapped offsets
    always_comb begin
        rdata_d = '0;
        if (!we_i) begin
            for (int i = 0; i < NR_HARTS; i++) begin
                if (hit_msip[i]) begin
                    rdata_d = reg_data_t'(msip_q[i]);
                end
                if (hit_cmp[i]) begin
                    rdata_d = mtimecmp_q[i];
                end
            end
            if (hit_mtime) begin
                rdata_d = mtime_q;
            end
        end
    end

    // --------------------
    // Register update
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtime_q <= '0;
            msip_q  <= '0;
            for (int i = 0; i < NR_HARTS; i++) begin
                mtimecmp_q[i] <= MTIMECMP_RESET;
            end
            rsp_q   <= 1'b0;
        end else begin
            // Bus write beats the tick in the same cycle
            if (wr_en && hit_mtime) begin
                mtime_q <= wdata_i;
            end else if (tick_i) begin
                mtime_q <= mtime_q + reg_data_t'(1);
            end
            for (int i = 0; i < NR_HARTS; i++) begin
                // Only bit 0 of msip is stored
                if (wr_en && hit_msip[i]) begin
                    msip_q[i] <= wdata_i[0];
                end
                if (wr_en && hit_cmp[i]) begin
                    mtimecmp_q[i] <= wdata_i;
                end
            end
            // Every grant is answered one cycle later
            rsp_q   <= req_i;
        end
    end

    // Read data captured alongside the response strobe
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            rdata_q <= rdata_d;
        end
    end

    assign rsp_o   = rsp_q;
    assign rdata_o = rdata_q;

    // --------------------
    // Interrupts
    // --------------------
    // Timer stays posted until mtimecmp is moved past mtime
    always_comb begin
        for (int i = 0; i < NR_HARTS; i++) begin
            timer_irq_o[i] = (mtime_q >= mtimecmp_q[i]);
        end
    end

    assign ipi_o = msip_q;

endmodule

/* hw/clint_top.sv */
`timescale 1ns/1ps

module clint_top
    import clint_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       testmode_i,
    // Slow real-time clock, asynchronous to clk_i
    input  logic       rtc_i,
    // Port 0, hart side
    input  logic       p0_req_i,
    input  logic       p0_we_i,
    input  reg_addr_t  p0_addr_i,
    input  reg_data_t  p0_wdata_i,
    output logic       p0_rsp_o,
    output reg_data_t  p0_rdata_o,
    // Port 1, debug side
    input  logic       p1_req_i,
    input  logic       p1_we_i,
    input  reg_addr_t  p1_addr_i,
    input  reg_data_t  p1_wdata_i,
    output logic       p1_rsp_o,
    output reg_data_t  p1_rdata_o,
    // Per-hart interrupts
    output hart_mask_t timer_irq_o,
    output hart_mask_t ipi_o
);

    // Arbiter to register block
    logic      gnt;
    logic      gnt_we;
    reg_addr_t gnt_addr;
    reg_data_t gnt_wdata;
    logic      blk_rsp;
    reg_data_t blk_rdata;
    // mtime increment pulse
    logic      tick;

    // --------------------
    // Request arbitration
    // --------------------
    reg_bus_arbiter u_arb (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .p0_req_i    (p0_req_i),
        .p0_we_i     (p0_we_i),
        .p0_addr_i   (p0_addr_i),
        .p0_wdata_i  (p0_wdata_i),
        .p0_rsp_o    (p0_rsp_o),
        .p0_rdata_o  (p0_rdata_o),
        .p1_req_i    (p1_req_i),
        .p1_we_i     (p1_we_i),
        .p1_addr_i   (p1_addr_i),
        .p1_wdata_i  (p1_wdata_i),
        .p1_rsp_o    (p1_rsp_o),
        .p1_rdata_o  (p1_rdata_o),
        .gnt_o       (gnt),
        .gnt_we_o    (gnt_we),
        .gnt_addr_o  (gnt_addr),
        .gnt_wdata_o (gnt_wdata),
        .blk_rsp_i   (blk_rsp),
        .blk_rdata_i (blk_rdata)
    );

    // --------------------
    // Registers and IRQs
    // --------------------
    clint_regs u_regs (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .tick_i      (tick),
        .req_i       (gnt),
        .we_i        (gnt_we),
        .addr_i      (gnt_addr),
        .wdata_i     (gnt_wdata),
        .rsp_o       (blk_rsp),
        .rdata_o     (blk_rdata),
        .timer_irq_o (timer_irq_o),
        .ipi_o       (ipi_o)
    );

    // mtime freezes in test mode
    rtc_edge_sync u_rtc_sync (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .en_i    (~testmode_i),
        .async_i (rtc_i),
        .rise_o  (tick)
    );

endmodule

/* bench/clint_assert.sv */
`timescale 1ns/1ps

module clint_assert (
    input  logic       clk_i,
    input  logic       rst_ni,
    // Full flags of the two request slots
    input  logic [1:0] slot_v_i,
    // Grant towards the register block
    input  logic       gnt_i,
    // Block response strobe
    input  logic       rsp_i,
    // Per-port response strobes
    input  logic       p0_rsp_i,
    input  logic       p1_rsp_i
);

    // --------------------
    // Grant rules
    // --------------------
    // Each grant drains one slot, so two slots never empty together
    a_one_grant : assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0($past(slot_v_i) & ~slot_v_i))
        else $error("more than one grant in a cycle");

    // Block answers exactly one cycle after the grant
    a_rsp_follows : assert property (@(posedge clk_i) disable iff (!rst_ni)
        gnt_i |=> rsp_i)
        else $error("grant without a block response in the next cycle");

    // --------------------
    // Response strobes
    // --------------------
    a_p0_single : assert property (@(posedge clk_i) disable iff (!rst_ni)
        p0_rsp_i |=> !p0_rsp_i)
        else $error("port 0 response strobe high for two cycles");

    a_p1_single : assert property (@(posedge clk_i) disable iff (!rst_ni)
        p1_rsp_i |=> !p1_rsp_i)
        else $error("port 1 response strobe high for two cycles");

endmodule

/* bench/clint_tb.sv */
`timescale 1ns/1ps

module clint_tb
    import clint_pkg::*;
();

    logic       clk_i;
    logic       rst_ni;
    logic       testmode_i;
    logic       rtc_i;
    logic       p0_req_i;
    logic       p0_we_i;
    reg_addr_t  p0_addr_i;
    reg_data_t  p0_wdata_i;
    logic       p0_rsp_o;
    reg_data_t  p0_rdata_o;
    logic       p1_req_i;
    logic       p1_we_i;
    reg_addr_t  p1_addr_i;
    reg_data_t  p1_wdata_i;
    logic       p1_rsp_o;
    reg_data_t  p1_rdata_o;
    hart_mask_t timer_irq_o;
    hart_mask_t ipi_o;

    // Reference model state
    reg_data_t   mtime_m;
    reg_data_t   cmp_m [NR_HARTS];
    hart_mask_t  msip_m;
    // Request and response bookkeeping per port
    int unsigned req_cnt [NR_PORTS];
    int unsigned rsp_cnt [NR_PORTS];
    // rtc_i rising edges made while counting is enabled
    int unsigned rises;
    reg_addr_t   addr;
    int          port;

    clint_top uut (.*);

    // Slot drain, grant and both response paths are visible in the arbiter
    bind reg_bus_arbiter clint_assert u_arb_assert (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .slot_v_i  (slot_v_q),
        .gnt_i     (gnt_o),
        .rsp_i     (blk_rsp_i),
        .p0_rsp_i  (p0_rsp_o),
        .p1_rsp_i  (p1_rsp_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Count response strobes where they are stable
    always @(negedge clk_i) begin
        if (p0_rsp_o) rsp_cnt[0]++;
        if (p1_rsp_o) rsp_cnt[1]++;
    end

    // --------------------
    // Failure reporting
    // --------------------
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input reg_data_t exp, input reg_data_t act);
        if (act !== exp) fail_run($sformatf("FAILED %s expected 0x%h actual 0x%h", name, exp, act));
    endtask

    task automatic check_mask(input string name, input hart_mask_t exp, input hart_mask_t act);
        if (act !== exp) fail_run($sformatf("FAILED %s expected 0x%h actual 0x%h", name, exp, act));
    endtask

    task automatic check_count(input string name, input int unsigned exp, input int unsigned act);
        if (act != exp) fail_run($sformatf("FAILED %s expected 0x%h actual 0x%h", name, exp, act));
    endtask

    // --------------------
    // Reference model
    // --------------------
    function automatic reg_addr_t msip_addr(input int h);
        return MSIP_BASE + reg_addr_t'(HART_STRIDE * h);
    endfunction

    function automatic reg_addr_t cmp_addr(input int h);
        return MTIMECMP_BASE + reg_addr_t'(HART_STRIDE * h);
    endfunction

    // Index 0..1 msip, 2..3 mtimecmp, 4 mtime
    function automatic reg_addr_t mapped_addr(input int k);
        if (k < 2) return msip_addr(k);
        if (k < 4) return cmp_addr(k - 2);
        return MTIME_BASE;
    endfunction

    function automatic logic is_mapped(input reg_addr_t a);
        for (int k = 0; k < 5; k++) begin
            if (a == mapped_addr(k)) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic reg_data_t model_read(input reg_addr_t a);
        reg_data_t d;
        d = '0;
        for (int h = 0; h < NR_HARTS; h++) begin
            if (a == msip_addr(h)) d = reg_data_t'(msip_m[h]);
            if (a == cmp_addr(h)) d = cmp_m[h];
        end
        if (a == MTIME_BASE) d = mtime_m;
        return d;
    endfunction

    // Unmapped offsets fall through untouched
    task automatic model_write(input reg_addr_t a, input reg_data_t d);
        for (int h = 0; h < NR_HARTS; h++) begin
            if (a == msip_addr(h)) msip_m[h] = d[0];
            if (a == cmp_addr(h)) cmp_m[h] = d;
        end
        if (a == MTIME_BASE) mtime_m = d;
    endtask

    function automatic reg_data_t rand64();
        return {$urandom, $urandom};
    endfunction

    function automatic reg_addr_t pick_unmapped();
        reg_addr_t a;
        a = reg_addr_t'($urandom);
        while (is_mapped(a)) a = reg_addr_t'($urandom);
        return a;
    endfunction

    // Compare value equal to, just above or just below mtime, or anywhere
    function automatic reg_data_t near_cmp();
        int unsigned mode;
        mode = $urandom % 3;
        if (mode == 0) return rand64();
        if (mode == 1) return mtime_m + reg_data_t'($urandom % 3);
        return mtime_m - reg_data_t'($urandom % 3);
    endfunction

    task automatic check_irqs();
        hart_mask_t exp_t;
        for (int h = 0; h < NR_HARTS; h++) exp_t[h] = (mtime_m >= cmp_m[h]);
        check_mask("timer_irq_o", exp_t, timer_irq_o);
        check_mask("ipi_o", msip_m, ipi_o);
    endtask

    // --------------------
    // Bus access
    // --------------------
    // Called on a falling edge, strobe covers exactly one rising edge
    task automatic access(input int p, input logic we, input reg_addr_t a,
                          input reg_data_t wd, output reg_data_t rd);
        int   cycles;
        logic seen;
        if (p == 0) begin
            p0_req_i = 1'b1;
            p0_we_i = we;
            p0_addr_i = a;
            p0_wdata_i = wd;
        end else begin
            p1_req_i = 1'b1;
            p1_we_i = we;
            p1_addr_i = a;
            p1_wdata_i = wd;
        end
        req_cnt[p]++;
        @(negedge clk_i);
        if (p == 0) p0_req_i = 1'b0;
        else p1_req_i = 1'b0;
        seen = 1'b0;
        cycles = 0;
        rd = '0;
        while (!seen && cycles < 50) begin
            @(negedge clk_i);
            cycles++;
            seen = (p == 0) ? p0_rsp_o : p1_rsp_o;
            rd = (p == 0) ? p0_rdata_o : p1_rdata_o;
        end
        if (!seen) fail_run($sformatf("timeout waiting for a response on port %0d", p));
    endtask

    task automatic run_op(input int p, input logic we, input reg_addr_t a, input reg_data_t wd);
        reg_data_t exp;
        reg_data_t rd;
        exp = we ? '0 : model_read(a);
        access(p, we, a, wd, rd);
        if (we) model_write(a, wd);
        check_data((p == 0) ? "p0_rdata_o" : "p1_rdata_o", exp, rd);
        check_irqs();
    endtask

    // Port 0 works on hart 0 and port 1 on hart 1, so order does not matter
    task automatic run_pair();
        int        d;
        logic      we0;
        logic      we1;
        reg_addr_t a0;
        reg_addr_t a1;
        reg_data_t w0;
        reg_data_t w1;
        reg_data_t e0;
        reg_data_t e1;
        reg_data_t r0;
        reg_data_t r1;
        we0 = 1'($urandom % 2);
        we1 = 1'($urandom % 2);
        a0 = ($urandom % 2) ? msip_addr(0) : cmp_addr(0);
        a1 = ($urandom % 2) ? msip_addr(1) : cmp_addr(1);
        w0 = rand64();
        w1 = rand64();
        e0 = we0 ? '0 : model_read(a0);
        e1 = we1 ? '0 : model_read(a1);
        d = $urandom % 3;
        fork
            access(0, we0, a0, w0, r0);
            begin
                repeat (d) @(negedge clk_i);
                access(1, we1, a1, w1, r1);
            end
        join
        if (we0) model_write(a0, w0);
        if (we1) model_write(a1, w1);
        check_data("p0_rdata_o", e0, r0);
        check_data("p1_rdata_o", e1, r1);
        check_irqs();
    endtask

    // Gaps of at least 4 cycles, then a hold so the last tick lands
    task automatic toggle_rtc(input int unsigned n);
        int unsigned gap;
        for (int unsigned k = 0; k < n; k++) begin
            rtc_i = ~rtc_i;
            if (rtc_i && !testmode_i) rises++;
            gap = 4 + $urandom % 4;
            repeat (gap) @(negedge clk_i);
        end
        repeat (6) @(negedge clk_i);
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        rst_ni = 1'b0;
        testmode_i = 1'b0;
        rtc_i = 1'b0;
        p0_req_i = 1'b0;
        p0_we_i = 1'b0;
        p0_addr_i = '0;
        p0_wdata_i = '0;
        p1_req_i = 1'b0;
        p1_we_i = 1'b0;
        p1_addr_i = '0;
        p1_wdata_i = '0;
        void'($urandom(18630));
        mtime_m = '0;
        msip_m = '0;
        for (int h = 0; h < NR_HARTS; h++) cmp_m[h] = MTIMECMP_RESET;
        repeat (3) @(negedge clk_i);
        rst_ni = 1'b1;
        @(negedge clk_i);

        // Reset values
        check_irqs();
        for (int k = 0; k < 5; k++) run_op(k % 2, 1'b0, mapped_addr(k), '0);

        // Random mapped traffic, single and paired
        repeat (40) run_op($urandom % 2, 1'($urandom % 2), mapped_addr($urandom % 4), rand64());
        repeat (30) run_pair();

        // Unmapped offsets read zero and leave the map alone
        repeat (20) begin
            addr = pick_unmapped();
            port = $urandom % 2;
            run_op(port, 1'b1, addr, rand64());
            run_op(port, 1'b0, addr, '0);
        end
        for (int k = 0; k < 5; k++) run_op(k % 2, 1'b0, mapped_addr(k), '0);

        // mtime counting, then frozen in test mode, then counting again
        rises = 0;
        toggle_rtc(1 + $urandom % 10);
        mtime_m = mtime_m + reg_data_t'(rises);
        run_op(0, 1'b0, MTIME_BASE, '0);
        testmode_i = 1'b1;
        repeat (4) @(negedge clk_i);
        rises = 0;
        toggle_rtc(2 + $urandom % 8);
        run_op(1, 1'b0, MTIME_BASE, '0);
        testmode_i = 1'b0;
        repeat (4) @(negedge clk_i);
        toggle_rtc(1 + $urandom % 10);
        mtime_m = mtime_m + reg_data_t'(rises);
        run_op(1, 1'b0, MTIME_BASE, '0);

        // Timer compare and software interrupts
        repeat (20) begin
            run_op($urandom % 2, 1'b1, MTIME_BASE, rand64());
            for (int h = 0; h < NR_HARTS; h++) run_op($urandom % 2, 1'b1, cmp_addr(h), near_cmp());
            run_op($urandom % 2, 1'b1, msip_addr($urandom % 2), rand64());
        end

        repeat (4) @(negedge clk_i);
        check_count("p0_rsp_o count", req_cnt[0], rsp_cnt[0]);
        check_count("p1_rsp_o count", req_cnt[1], rsp_cnt[1]);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* list.f */
hw/clint_pkg.sv
hw/rtc_edge_sync.sv
hw/reg_bus_arbiter.sv
hw/clint_regs.sv
hw/clint_top.sv
bench/clint_assert.sv
bench/clint_tb.sv
